// File: logic/cache_pkg.sv
package cache_pkg;

    // Width of one byte-enable lane
    localparam int BYTE_LEN_IN_BITS = 8;

    // Controller states
    typedef enum logic [2:0]
    {
        // Waiting for a core request, req_ready high
        ST_IDLE        = 3'd0,

        // Tag array accessed, valid bit registers on the next edge
        ST_LOOKUP      = 3'd1,

        // Tag and valid are both available, hit or miss decided here
        ST_COMPARE     = 3'd2,

        // Read miss, waiting for the refill word from memory
        ST_REFILL_WAIT = 3'd3,

        // Write-through sent, waiting for the memory acknowledge
        ST_WRITE_WAIT  = 3'd4,

        // One-cycle response to the core
        ST_RESPOND     = 3'd5
    } cache_state_e;

endpackage

// File: logic/single_port_lutram.sv
`timescale 1ns/1ps

module single_port_lutram
#(
    parameter SINGLE_ENTRY_WIDTH_IN_BITS = 64,
    parameter NUM_SET                    = 64,
    parameter WITH_VALID_REG_ARRAY       = "Yes"
)
(
    clk_in,
    reset_in,
    access_en_in,
    write_en_in,
    access_set_addr_in,
    write_entry_in,
    read_entry_out,
    read_valid_out
);

    localparam SET_PTR_WIDTH  = $clog2(NUM_SET);
    localparam WRITE_MASK_LEN = SINGLE_ENTRY_WIDTH_IN_BITS / cache_pkg::BYTE_LEN_IN_BITS;

    input  logic                                    clk_in;
    input  logic                                    reset_in;
    input  logic                                    access_en_in;
    input  logic [WRITE_MASK_LEN - 1 : 0]           write_en_in;
    input  logic [SET_PTR_WIDTH - 1 : 0]            access_set_addr_in;
    input  logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] write_entry_in;
    output logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] read_entry_out;
    output logic                                    read_valid_out;

    logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1 : 0] lut_ram [NUM_SET];

    generate
        if (WITH_VALID_REG_ARRAY == "Yes")
        begin : gen_valid
            logic [NUM_SET - 1 : 0] valid_array;

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    valid_array    <= '0;
                    read_valid_out <= 1'b0;
                end
                else
                begin
                    // Any byte written marks the whole set valid
                    if (access_en_in && |write_en_in)
                    begin
                        valid_array[access_set_addr_in] <= 1'b1;
                    end

                    // Old value is seen, a write lands one cycle later
                    if (access_en_in)
                        read_valid_out <= valid_array[access_set_addr_in];
                    else
                        read_valid_out <= 1'b0;
                end
            end
        end
        else
        begin : gen_no_valid
            // Every entry counts as valid once out of reset
            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                    read_valid_out <= 1'b0;
                else
                    read_valid_out <= 1'b1;
            end
        end
    endgenerate

    always_ff @(posedge clk_in)
    begin
        for (int lane = 0; lane < WRITE_MASK_LEN; lane++)
        begin
            if (access_en_in && write_en_in[lane])
            begin
                lut_ram[access_set_addr_in][lane * cache_pkg::BYTE_LEN_IN_BITS +:
                    cache_pkg::BYTE_LEN_IN_BITS] <=
                    write_entry_in[lane * cache_pkg::BYTE_LEN_IN_BITS +:
                    cache_pkg::BYTE_LEN_IN_BITS];
            end
        end
    end

    // Combinational read
    assign read_entry_out = lut_ram[access_set_addr_in];

endmodule

// File: logic/cache_controller.sv
`timescale 1ns/1ps

module cache_controller
#(
    parameter DATA_WIDTH = 64,
    parameter NUM_SET    = 64,
    parameter ADDR_WIDTH = 16
)
(
    clk_in,
    reset_in,
    req_valid,
    req_write,
    req_addr,
    req_byte_en,
    req_wdata,
    req_ready,
    resp_valid,
    resp_rdata,
    mem_req,
    mem_write,
    mem_addr,
    mem_byte_en,
    mem_wdata,
    mem_resp_valid,
    mem_rdata,
    tag_access_en,
    tag_write_en,
    tag_set_addr,
    tag_write_entry,
    tag_read_entry,
    tag_read_valid,
    data_access_en,
    data_write_en,
    data_set_addr,
    data_write_entry,
    data_read_entry
);

    localparam SET_PTR_WIDTH   = $clog2(NUM_SET);
    localparam TAG_WIDTH       = ADDR_WIDTH - SET_PTR_WIDTH;
    localparam BYTE_LEN        = cache_pkg::BYTE_LEN_IN_BITS;
    localparam TAG_ENTRY_WIDTH = ((TAG_WIDTH + BYTE_LEN - 1) / BYTE_LEN) * BYTE_LEN;
    localparam TAG_MASK_LEN    = TAG_ENTRY_WIDTH / BYTE_LEN;
    localparam WRITE_MASK_LEN  = DATA_WIDTH / BYTE_LEN;

    input  logic                           clk_in;
    input  logic                           reset_in;

    input  logic                           req_valid;
    input  logic                           req_write;
    input  logic [ADDR_WIDTH - 1 : 0]      req_addr;
    input  logic [WRITE_MASK_LEN - 1 : 0]  req_byte_en;
    input  logic [DATA_WIDTH - 1 : 0]      req_wdata;
    output logic                           req_ready;
    output logic                           resp_valid;
    output logic [DATA_WIDTH - 1 : 0]      resp_rdata;

    output logic                           mem_req;
    output logic                           mem_write;
    output logic [ADDR_WIDTH - 1 : 0]      mem_addr;
    output logic [WRITE_MASK_LEN - 1 : 0]  mem_byte_en;
    output logic [DATA_WIDTH - 1 : 0]      mem_wdata;
    input  logic                           mem_resp_valid;
    input  logic [DATA_WIDTH - 1 : 0]      mem_rdata;

    output logic                           tag_access_en;
    output logic [TAG_MASK_LEN - 1 : 0]    tag_write_en;
    output logic [SET_PTR_WIDTH - 1 : 0]   tag_set_addr;
    output logic [TAG_ENTRY_WIDTH - 1 : 0] tag_write_entry;
    input  logic [TAG_ENTRY_WIDTH - 1 : 0] tag_read_entry;
    input  logic                           tag_read_valid;

    output logic                           data_access_en;
    output logic [WRITE_MASK_LEN - 1 : 0]  data_write_en;
    output logic [SET_PTR_WIDTH - 1 : 0]   data_set_addr;
    output logic [DATA_WIDTH - 1 : 0]      data_write_entry;
    input  logic [DATA_WIDTH - 1 : 0]      data_read_entry;

    cache_pkg::cache_state_e state;
    cache_pkg::cache_state_e next_state;

    // Captured request, held until the next accept
    logic                          req_write_q;
    logic [ADDR_WIDTH - 1 : 0]     req_addr_q;
    logic [WRITE_MASK_LEN - 1 : 0] req_byte_en_q;
    logic [DATA_WIDTH - 1 : 0]     req_wdata_q;
    logic [DATA_WIDTH - 1 : 0]     rdata_q;

    logic [SET_PTR_WIDTH - 1 : 0]  req_set;
    logic [TAG_WIDTH - 1 : 0]      req_tag;
    logic                          accept;
    logic                          hit;

    assign accept  = (state == cache_pkg::ST_IDLE) && req_valid;
    assign req_set = req_addr_q[SET_PTR_WIDTH - 1 : 0];
    assign req_tag = req_addr_q[ADDR_WIDTH - 1 : SET_PTR_WIDTH];

    // Only meaningful in ST_COMPARE, when the valid bit has been registered
    assign hit = tag_read_valid && (tag_read_entry[TAG_WIDTH - 1 : 0] == req_tag);

    assign req_ready  = (state == cache_pkg::ST_IDLE);
    assign resp_valid = (state == cache_pkg::ST_RESPOND);
    assign resp_rdata = rdata_q;

    // Memory request fields come straight from the captured request
    assign mem_write   = req_write_q;
    assign mem_addr    = req_addr_q;
    assign mem_byte_en = req_write_q ? req_byte_en_q : '1;
    assign mem_wdata   = req_wdata_q;

    // Set address stays fixed from lookup through compare and refill
    assign tag_set_addr    = req_set;
    assign data_set_addr   = req_set;
    assign tag_write_entry = TAG_ENTRY_WIDTH'(req_tag);

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state       <= cache_pkg::ST_IDLE;
            mem_req     <= 1'b0;
            req_write_q <= 1'b0;
        end
        else
        begin
            state <= next_state;

            if (accept)
                req_write_q <= req_write;

            // One-cycle pulse on leaving compare, every path but a read hit
            mem_req <= (state == cache_pkg::ST_COMPARE) && (req_write_q || !hit);
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            req_addr_q    <= req_addr;
            req_byte_en_q <= req_byte_en;
            req_wdata_q   <= req_wdata;
        end

        if (state == cache_pkg::ST_COMPARE && !req_write_q && hit)
            rdata_q <= data_read_entry;
        else if (state == cache_pkg::ST_REFILL_WAIT && mem_resp_valid)
            rdata_q <= mem_rdata;
    end

    always_comb
    begin
        next_state       = state;
        tag_access_en    = 1'b0;
        tag_write_en     = '0;
        data_access_en   = 1'b0;
        data_write_en    = '0;
        data_write_entry = req_wdata_q;

        case (state)
            cache_pkg::ST_IDLE:
            begin
                if (req_valid)
                    next_state = cache_pkg::ST_LOOKUP;
            end

            cache_pkg::ST_LOOKUP:
            begin
                tag_access_en = 1'b1;
                next_state    = cache_pkg::ST_COMPARE;
            end

            cache_pkg::ST_COMPARE:
            begin
                if (req_write_q)
                begin
                    // Merge bytes on a hit, no allocate on a miss
                    if (hit)
                    begin
                        data_access_en = 1'b1;
                        data_write_en  = req_byte_en_q;
                    end
                    next_state = cache_pkg::ST_WRITE_WAIT;
                end
                else if (hit)
                    next_state = cache_pkg::ST_RESPOND;
                else
                    next_state = cache_pkg::ST_REFILL_WAIT;
            end

            cache_pkg::ST_REFILL_WAIT:
            begin
                if (mem_resp_valid)
                begin
                    // Whole line fill, the tag write also sets the valid bit
                    tag_access_en    = 1'b1;
                    tag_write_en     = '1;
                    data_access_en   = 1'b1;
                    data_write_en    = '1;
                    data_write_entry = mem_rdata;
                    next_state       = cache_pkg::ST_RESPOND;
                end
            end

            cache_pkg::ST_WRITE_WAIT:
            begin
                if (mem_resp_valid)
                    next_state = cache_pkg::ST_RESPOND;
            end

            cache_pkg::ST_RESPOND:
            begin
                next_state = cache_pkg::ST_IDLE;
            end

            default:
            begin
                next_state = cache_pkg::ST_IDLE;
            end
        endcase
    end

endmodule

// File: logic/cache_top.sv
`timescale 1ns/1ps

module cache_top
#(
    parameter DATA_WIDTH = 64,
    parameter NUM_SET    = 64,
    parameter ADDR_WIDTH = 16
)
(
    input  logic                          clk_in,
    input  logic                          reset_in,

    // Core port
    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [ADDR_WIDTH - 1 : 0]     req_addr,
    input  logic [DATA_WIDTH / cache_pkg::BYTE_LEN_IN_BITS - 1 : 0] req_byte_en,
    input  logic [DATA_WIDTH - 1 : 0]     req_wdata,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [DATA_WIDTH - 1 : 0]     resp_rdata,

    // Memory port
    output logic                          mem_req,
    output logic                          mem_write,
    output logic [ADDR_WIDTH - 1 : 0]     mem_addr,
    output logic [DATA_WIDTH / cache_pkg::BYTE_LEN_IN_BITS - 1 : 0] mem_byte_en,
    output logic [DATA_WIDTH - 1 : 0]     mem_wdata,
    input  logic                          mem_resp_valid,
    input  logic [DATA_WIDTH - 1 : 0]     mem_rdata
);

    localparam SET_PTR_WIDTH   = $clog2(NUM_SET);
    localparam TAG_WIDTH       = ADDR_WIDTH - SET_PTR_WIDTH;
    localparam BYTE_LEN        = cache_pkg::BYTE_LEN_IN_BITS;
    localparam TAG_ENTRY_WIDTH = ((TAG_WIDTH + BYTE_LEN - 1) / BYTE_LEN) * BYTE_LEN;
    localparam TAG_MASK_LEN    = TAG_ENTRY_WIDTH / BYTE_LEN;
    localparam WRITE_MASK_LEN  = DATA_WIDTH / BYTE_LEN;

    logic                           tag_access_en;
    logic [TAG_MASK_LEN - 1 : 0]    tag_write_en;
    logic [SET_PTR_WIDTH - 1 : 0]   tag_set_addr;
    logic [TAG_ENTRY_WIDTH - 1 : 0] tag_write_entry;
    logic [TAG_ENTRY_WIDTH - 1 : 0] tag_read_entry;
    logic                           tag_read_valid;

    logic                           data_access_en;
    logic [WRITE_MASK_LEN - 1 : 0]  data_write_en;
    logic [SET_PTR_WIDTH - 1 : 0]   data_set_addr;
    logic [DATA_WIDTH - 1 : 0]      data_write_entry;
    logic [DATA_WIDTH - 1 : 0]      data_read_entry;

    // Tag store, its valid bits mark filled lines
    single_port_lutram
    #(
        .SINGLE_ENTRY_WIDTH_IN_BITS (TAG_ENTRY_WIDTH),
        .NUM_SET                    (NUM_SET),
        .WITH_VALID_REG_ARRAY       ("Yes")
    )
    tag_array
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .access_en_in       (tag_access_en),
        .write_en_in        (tag_write_en),
        .access_set_addr_in (tag_set_addr),
        .write_entry_in     (tag_write_entry),
        .read_entry_out     (tag_read_entry),
        .read_valid_out     (tag_read_valid)
    );

    // Data store, validity comes from the tag array
    single_port_lutram
    #(
        .SINGLE_ENTRY_WIDTH_IN_BITS (DATA_WIDTH),
        .NUM_SET                    (NUM_SET),
        .WITH_VALID_REG_ARRAY       ("No")
    )
    data_array
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .access_en_in       (data_access_en),
        .write_en_in        (data_write_en),
        .access_set_addr_in (data_set_addr),
        .write_entry_in     (data_write_entry),
        .read_entry_out     (data_read_entry),
        .read_valid_out     ()
    );

    cache_controller
    #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_SET    (NUM_SET),
        .ADDR_WIDTH (ADDR_WIDTH)
    )
    controller
    (
        .clk_in           (clk_in),
        .reset_in         (reset_in),
        .req_valid        (req_valid),
        .req_write        (req_write),
        .req_addr         (req_addr),
        .req_byte_en      (req_byte_en),
        .req_wdata        (req_wdata),
        .req_ready        (req_ready),
        .resp_valid       (resp_valid),
        .resp_rdata       (resp_rdata),
        .mem_req          (mem_req),
        .mem_write        (mem_write),
        .mem_addr         (mem_addr),
        .mem_byte_en      (mem_byte_en),
        .mem_wdata        (mem_wdata),
        .mem_resp_valid   (mem_resp_valid),
        .mem_rdata        (mem_rdata),
        .tag_access_en    (tag_access_en),
        .tag_write_en     (tag_write_en),
        .tag_set_addr     (tag_set_addr),
        .tag_write_entry  (tag_write_entry),
        .tag_read_entry   (tag_read_entry),
        .tag_read_valid   (tag_read_valid),
        .data_access_en   (data_access_en),
        .data_write_en    (data_write_en),
        .data_set_addr    (data_set_addr),
        .data_write_entry (data_write_entry),
        .data_read_entry  (data_read_entry)
    );

endmodule

// File: tests/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    localparam DATA_WIDTH     = 64;
    localparam NUM_SET        = 64;
    localparam ADDR_WIDTH     = 16;
    localparam SET_PTR_WIDTH  = $clog2(NUM_SET);
    localparam TAG_WIDTH      = ADDR_WIDTH - SET_PTR_WIDTH;
    localparam BYTE_LEN       = cache_pkg::BYTE_LEN_IN_BITS;
    localparam WRITE_MASK_LEN = DATA_WIDTH / BYTE_LEN;
    localparam TIMEOUT_CYCLES = 50;
    localparam NUM_RANDOM_OPS = 400;

    logic                          clk_in;
    logic                          reset_in;
    logic                          req_valid;
    logic                          req_write;
    logic [ADDR_WIDTH - 1 : 0]     req_addr;
    logic [WRITE_MASK_LEN - 1 : 0] req_byte_en;
    logic [DATA_WIDTH - 1 : 0]     req_wdata;
    logic                          req_ready;
    logic                          resp_valid;
    logic [DATA_WIDTH - 1 : 0]     resp_rdata;
    logic                          mem_req;
    logic                          mem_write;
    logic [ADDR_WIDTH - 1 : 0]     mem_addr;
    logic [WRITE_MASK_LEN - 1 : 0] mem_byte_en;
    logic [DATA_WIDTH - 1 : 0]     mem_wdata;
    logic                          mem_resp_valid;
    logic [DATA_WIDTH - 1 : 0]     mem_rdata;

    // Memory model and shadow copy of the tag store
    logic [DATA_WIDTH - 1 : 0] mem_words [logic [ADDR_WIDTH - 1 : 0]];
    logic [TAG_WIDTH - 1 : 0]  shadow_tag [NUM_SET];
    logic [NUM_SET - 1 : 0]    shadow_valid;
    integer                    seed;
    int                        hit_count;

    cache_top
    #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_SET    (NUM_SET),
        .ADDR_WIDTH (ADDR_WIDTH)
    )
    UUT
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_byte_en    (req_byte_en),
        .req_wdata      (req_wdata),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_rdata     (resp_rdata),
        .mem_req        (mem_req),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_byte_en    (mem_byte_en),
        .mem_wdata      (mem_wdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_rdata      (mem_rdata)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    task automatic check_value(input string name, input logic [DATA_WIDTH - 1 : 0] expected,
                               input logic [DATA_WIDTH - 1 : 0] actual);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("Errors found");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic timeout_failure(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        $display("Errors found");
        $fatal(1, "Timeout");
    endtask

    function automatic int rand_below(input int limit);
        return int'($unsigned($random(seed)) % $unsigned(limit));
    endfunction

    function automatic logic [DATA_WIDTH - 1 : 0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // Unwritten words get a pattern built from every address bit
    function automatic logic [DATA_WIDTH - 1 : 0] mem_read(input logic [ADDR_WIDTH - 1 : 0] addr);
        if (mem_words.exists(addr))
            return mem_words[addr];
        else
            return {addr, ~addr, addr ^ 16'ha55a, addr[7:0], addr[15:8]};
    endfunction

    task automatic mem_update(input logic [ADDR_WIDTH - 1 : 0] addr,
                              input logic [WRITE_MASK_LEN - 1 : 0] byte_en,
                              input logic [DATA_WIDTH - 1 : 0] wdata);
        logic [DATA_WIDTH - 1 : 0] word;
        word = mem_read(addr);
        for (int lane = 0; lane < WRITE_MASK_LEN; lane++)
        begin
            if (byte_en[lane])
                word[lane * BYTE_LEN +: BYTE_LEN] = wdata[lane * BYTE_LEN +: BYTE_LEN];
        end
        mem_words[addr] = word;
    endtask

    // Few tags and sets so that hits and conflicts are common
    function automatic logic [ADDR_WIDTH - 1 : 0] pick_addr();
        logic [TAG_WIDTH - 1 : 0]     tag;
        logic [SET_PTR_WIDTH - 1 : 0] set;
        tag = (rand_below(4) == 3) ? '1 : TAG_WIDTH'(rand_below(3));
        set = (rand_below(5) == 4) ? '1 : SET_PTR_WIDTH'(rand_below(3));
        return {tag, set};
    endfunction

    task automatic apply_reset();
        @(negedge clk_in);
        reset_in       = 1'b1;
        req_valid      = 1'b0;
        mem_resp_valid = 1'b0;
        repeat (5) @(negedge clk_in);
        reset_in     = 1'b0;
        shadow_valid = '0;
        check_value("req_ready", 64'(1), 64'(req_ready));
        check_value("resp_valid", 64'(0), 64'(resp_valid));
        check_value("mem_req", 64'(0), 64'(mem_req));
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!req_ready)
        begin
            @(negedge clk_in);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                timeout_failure("req_ready");
        end
    endtask

    task automatic wait_mem_req();
        int cycles;
        cycles = 0;
        while (!mem_req)
        begin
            check_value("resp_valid", 64'(0), 64'(resp_valid));
            @(negedge clk_in);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                timeout_failure("mem_req");
        end
    endtask

    task automatic wait_resp(output int cycles);
        cycles = 0;
        while (!resp_valid)
        begin
            check_value("mem_req", 64'(0), 64'(mem_req));
            @(negedge clk_in);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                timeout_failure("resp_valid");
        end
    endtask

    // Memory side of one request, answered after 1 to 4 cycles
    task automatic serve_mem_req(input logic write, input logic [ADDR_WIDTH - 1 : 0] addr,
                                 input logic [WRITE_MASK_LEN - 1 : 0] byte_en,
                                 input logic [DATA_WIDTH - 1 : 0] wdata);
        int delay;
        check_value("mem_write", 64'(write), 64'(mem_write));
        check_value("mem_addr", 64'(addr), 64'(mem_addr));
        if (write)
        begin
            check_value("mem_byte_en", 64'(byte_en), 64'(mem_byte_en));
            check_value("mem_wdata", wdata, mem_wdata);
            mem_update(addr, byte_en, wdata);
        end
        delay = 1 + rand_below(4);
        repeat (delay)
        begin
            @(negedge clk_in);
            check_value("mem_req", 64'(0), 64'(mem_req));
        end
        mem_resp_valid = 1'b1;
        mem_rdata      = write ? rand_word() : mem_read(addr);
        @(negedge clk_in);
        mem_resp_valid = 1'b0;
        check_value("resp_valid", 64'(1), 64'(resp_valid));
    endtask

    task automatic cache_access(input logic write, input logic [ADDR_WIDTH - 1 : 0] addr,
                                input logic [WRITE_MASK_LEN - 1 : 0] byte_en,
                                input logic [DATA_WIDTH - 1 : 0] wdata);
        logic [SET_PTR_WIDTH - 1 : 0] set;
        logic [TAG_WIDTH - 1 : 0]     tag;
        logic                         hit;
        logic [DATA_WIDTH - 1 : 0]    expected;
        int                           waited;
        set      = addr[SET_PTR_WIDTH - 1 : 0];
        tag      = addr[ADDR_WIDTH - 1 : SET_PTR_WIDTH];
        hit      = shadow_valid[set] && (shadow_tag[set] == tag);
        expected = mem_read(addr);
        wait_ready();
        req_valid   = 1'b1;
        req_write   = write;
        req_addr    = addr;
        req_byte_en = byte_en;
        req_wdata   = wdata;
        @(negedge clk_in);
        req_valid = 1'b0;
        check_value("req_ready", 64'(0), 64'(req_ready));
        if (write || !hit)
        begin
            wait_mem_req();
            serve_mem_req(write, addr, byte_en, wdata);
            // Only a read miss allocates
            if (!write)
            begin
                shadow_valid[set] = 1'b1;
                shadow_tag[set]   = tag;
            end
        end
        else
        begin
            wait_resp(waited);
            // Counted from the cycle that presents the request
            check_value("hit latency", 64'(3), 64'(waited + 1));
            hit_count++;
        end
        if (!write)
            check_value("resp_rdata", expected, resp_rdata);

        // One-cycle response and req_ready back high
        @(negedge clk_in);
        check_value("resp_valid", 64'(0), 64'(resp_valid));
        check_value("req_ready", 64'(1), 64'(req_ready));
    endtask

    task automatic run_random_ops(input int count);
        logic write;
        for (int op = 0; op < count; op++)
        begin
            if (rand_below(100) == 0)
                apply_reset();
            write = (rand_below(10) < 4);
            cache_access(write, pick_addr(), WRITE_MASK_LEN'(rand_below(256)), rand_word());
        end
    endtask

    initial
    begin
        seed           = 93953;
        hit_count      = 0;
        reset_in       = 1'b1;
        req_valid      = 1'b0;
        req_write      = 1'b0;
        req_addr       = '0;
        req_byte_en    = '0;
        req_wdata      = '0;
        mem_resp_valid = 1'b0;
        mem_rdata      = '0;
        apply_reset();

        // Cold miss, then the same word as a hit
        cache_access(1'b0, 16'h0042, '1, '0);
        cache_access(1'b0, 16'h0042, '1, '0);

        // Masked write to a cached line, read back the merge
        cache_access(1'b1, 16'h0042, 8'b1010_0101, 64'h0123_4567_89ab_cdef);
        cache_access(1'b0, 16'h0042, '1, '0);

        // Write miss leaves the line unallocated
        cache_access(1'b1, 16'h1283, 8'h0f, 64'hfeed_face_cafe_beef);
        cache_access(1'b0, 16'h1283, '1, '0);

        // Same set, different tags
        repeat (2)
        begin
            cache_access(1'b0, 16'h0045, '1, '0);
            cache_access(1'b0, 16'h0445, '1, '0);
        end

        // Reset drops every line
        apply_reset();
        cache_access(1'b0, 16'h0042, '1, '0);

        run_random_ops(NUM_RANDOM_OPS);

        $display("Finished %0d random accesses, %0d read hits in total", NUM_RANDOM_OPS,
                 hit_count);
        $display("No errors");
        $finish;
    end

endmodule

// File: src.f
logic/cache_pkg.sv
logic/single_port_lutram.sv
logic/cache_controller.sv
logic/cache_top.sv
tests/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" <<< "$output"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
